/* logic/adc_pkg.sv */
/*
  ADC word layout for one 9-lane deserializer, 10 bits per lane per clk_adc cycle.
  The lane above the channels carries the frame clock and is never streamed or captured.
*/
package adc_pkg;

  localparam int FRAME_LANE  = 8;              // frame-clock lane sits above the channels
  localparam int CHANNELS    = FRAME_LANE;     // lanes 0..7 are samples
  localparam int LANE_COUNT  = FRAME_LANE + 1; // 9 lanes from the deserializer
  localparam int LANE_BITS   = 10;             // adc resolution, bits per lane per word
  localparam int SAMPLE_BITS = 16;             // streamed sample, zero padded

  // one lane word, also the capture entry
  typedef logic [LANE_BITS-1:0] lane_t;

  // named view, msb first, so frame lands on bits 89:80
  typedef struct packed {
    lane_t                frame; // frame-clock pattern
    lane_t [CHANNELS-1:0] ch;    // sample channels, ch[0] at the bottom
  } adc_fields_t;

  // same 90 bits seen as a flat lane array or as frame plus channels
  typedef union packed {
    lane_t [LANE_COUNT-1:0] lanes; // indexed by lane number
    adc_fields_t            fields;
  } adc_word_u;

endpackage

/* logic/capture_pkg.sv */
/*
  Debug capture sizing. Depth must stay a power of two so the address wraps cleanly.
*/
package capture_pkg;

  localparam int CAPTURE_DEPTH = 2048;                   // entries per record
  localparam int CAPTURE_AW    = $clog2(CAPTURE_DEPTH);  // 11 address bits
  localparam int SEL_BITS      = 3;                      // picks one of 8 channels
  localparam int SYNC_STAGES   = 2;                      // flops on the quasi-static select

endpackage

/* logic/capture_rd_if.sv */
/*
  Read side of the capture memory. rd_data is valid one cycle after rd_en is sampled high.
*/
`timescale 1ns/10ps

interface capture_rd_if import adc_pkg::*, capture_pkg::*; ();

  logic                  rd_en;        // read strobe from the dump engine
  logic [CAPTURE_AW-1:0] rd_addr;      // entry to read
  logic                  dump_active;  // dump in progress, blocks new captures
  lane_t                 rd_data;      // registered memory output
  logic                  capture_done; // single pulse when the last entry is written

  modport ram (
    input  rd_en, rd_addr, dump_active,
    output rd_data, capture_done
  );

  modport dump (
    output rd_en, rd_addr, dump_active,
    input  rd_data, capture_done
  );

endinterface

/* logic/adc_lane_unpack.sv */
/*
  Reorders the bit-interleaved deserializer word into lanes and registers the stream.
  capture_sel is assumed quasi-static; a change needs SYNC_STAGES+1 cycles to land.
*/
`timescale 1ns/10ps

module adc_lane_unpack import adc_pkg::*, capture_pkg::*; (
  input  logic                            clk_adc,
  input  logic                            rst_adc_n,
  input  logic [LANE_COUNT*LANE_BITS-1:0] data_in,        // interleaved, lane k bit j at j*9+k
  input  logic                            sampling,       // level, marks valid words
  input  logic                            last,           // strobe on the final word of a line
  input  logic [SEL_BITS-1:0]             capture_sel,    // channel to record
  output logic [CHANNELS*SAMPLE_BITS-1:0] m_tdata,
  output logic                            m_tvalid,
  output logic                            m_tlast,
  output lane_t                           capture_sample  // selected channel, one cycle late
);

  adc_word_u                             word;      // reordered input
  logic [SYNC_STAGES-1:0][SEL_BITS-1:0]  sel_sync;  // select synchronizer chain

  // deserializer hands bits out round robin across the lanes
  always_comb begin
    for (int k = 0; k < LANE_COUNT; k++) begin
      for (int j = 0; j < LANE_BITS; j++) begin
        word.lanes[k][j] = data_in[j*LANE_COUNT + k]; // gather bit j of lane k
      end
    end
  end

  // stream payload, no reset needed on data
  always_ff @(posedge clk_adc) begin
    for (int n = 0; n < CHANNELS; n++) begin
      m_tdata[n*SAMPLE_BITS +: SAMPLE_BITS] <= SAMPLE_BITS'(word.fields.ch[n]); // zero extend
    end
  end

  // stream flags ride alongside the data
  always_ff @(posedge clk_adc or negedge rst_adc_n) begin
    if (!rst_adc_n) begin
      m_tvalid <= 1'b0;
      m_tlast  <= 1'b0;
    end else begin
      m_tvalid <= sampling; // same edge as the data register
      m_tlast  <= last;
    end
  end

  // select comes from a slow control domain
  always_ff @(posedge clk_adc or negedge rst_adc_n) begin
    if (!rst_adc_n) begin
      sel_sync <= '0;
    end else begin
      sel_sync <= {sel_sync[SYNC_STAGES-2:0], capture_sel}; // shift in at stage 0
    end
  end

  // capture tap, frame lane unreachable with a 3-bit select
  always_ff @(posedge clk_adc) begin
    capture_sample <= word.fields.ch[sel_sync[SYNC_STAGES-1]];
  end

  // last only makes sense on a word that is being sampled
  a_last_needs_valid: assert property (
    @(posedge clk_adc) disable iff (!rst_adc_n)
    m_tlast |-> m_tvalid
  ) else $error("m_tlast high without m_tvalid");

endmodule

/* logic/capture_ram.sv */
/*
  Capture write control and the 2048 x 10 record memory with a registered read port.
  go restarts a running capture at address 0 and is dropped while a dump is active.
*/
`timescale 1ns/10ps

module capture_ram import adc_pkg::*, capture_pkg::*; (
  input  logic          clk_adc,
  input  logic          rst_adc_n,
  input  logic          capture_go,     // single-cycle start request
  input  lane_t         capture_sample, // selected channel from the unpacker
  output logic          capture_busy,   // recording in progress
  capture_rd_if.ram     rd
);

  logic                  go_q;       // registered go, already masked by dump_active
  logic                  restart;    // clears the address and (re)starts recording
  logic                  in_capture; // write enable for the memory
  logic                  wr_last;    // address sits on the final entry
  logic [CAPTURE_AW-1:0] wr_addr;
  lane_t                 mem [CAPTURE_DEPTH];

  assign wr_last      = (wr_addr == CAPTURE_AW'(CAPTURE_DEPTH - 1));
  // done pulse closes the window so a late go cannot race the dump start
  assign restart      = go_q && !rd.dump_active && !rd.capture_done;
  assign capture_busy = in_capture;

  always_ff @(posedge clk_adc or negedge rst_adc_n) begin
    if (!rst_adc_n) begin
      go_q <= 1'b0;
    end else begin
      go_q <= capture_go && !rd.dump_active; // ignore go during a dump
    end
  end

  // capture flag and address, go has priority as restart
  always_ff @(posedge clk_adc or negedge rst_adc_n) begin
    if (!rst_adc_n) begin
      in_capture      <= 1'b0;
      wr_addr         <= '0;
      rd.capture_done <= 1'b0;
    end else begin
      rd.capture_done <= in_capture && wr_last && !restart; // final write lands this edge
      if (restart) begin
        in_capture <= 1'b1;
        wr_addr    <= '0;
      end else if (in_capture) begin
        if (wr_last) begin
          in_capture <= 1'b0;           // record full, counter parks at all ones
        end else begin
          wr_addr <= wr_addr + 1'b1;
        end
      end
    end
  end

  // write port
  always_ff @(posedge clk_adc) begin
    if (in_capture) begin
      mem[wr_addr] <= capture_sample;
    end
  end

  // read port, one cycle latency
  always_ff @(posedge clk_adc) begin
    if (rd.rd_en) begin
      rd.rd_data <= mem[rd.rd_addr];
    end
  end

  // address only moves while recording or on a fresh start
  a_wr_addr_quiet: assert property (
    @(posedge clk_adc) disable iff (!rst_adc_n)
    !$stable(wr_addr) |-> $past(in_capture || restart)
  ) else $error("capture write address moved while idle");

endmodule

/* logic/capture_dump.sv */
/*
  Reads the whole record out once per completed capture, one entry per cycle.
  dump_valid trails capture_done by exactly 2 cycles and lasts CAPTURE_DEPTH cycles.
*/
`timescale 1ns/10ps

module capture_dump import adc_pkg::*, capture_pkg::*; (
  input  logic       clk_adc,
  input  logic       rst_adc_n,
  capture_rd_if.dump rd,
  output logic       dump_valid,
  output logic       dump_last,
  output lane_t      dump_data
);

  logic rd_final; // current read hits the last entry

  assign rd_final  = (rd.rd_addr == CAPTURE_AW'(CAPTURE_DEPTH - 1));
  assign dump_data = rd.rd_data; // memory output is already registered

  // read sequencer
  always_ff @(posedge clk_adc or negedge rst_adc_n) begin
    if (!rst_adc_n) begin
      rd.dump_active <= 1'b0;
      rd.rd_en       <= 1'b0;
      rd.rd_addr     <= '0;
    end else begin
      if (rd.capture_done && !rd.dump_active) begin
        rd.dump_active <= 1'b1;         // hold off new captures
        rd.rd_en       <= 1'b1;
        rd.rd_addr     <= '0;
      end else if (rd.rd_en) begin
        if (rd_final) begin
          rd.rd_en <= 1'b0;             // last read issued
        end else begin
          rd.rd_addr <= rd.rd_addr + 1'b1;
        end
      end else if (dump_last) begin
        rd.dump_active <= 1'b0;         // final entry is on the output now
      end
    end
  end

  // output flags delayed to match the read latency
  always_ff @(posedge clk_adc or negedge rst_adc_n) begin
    if (!rst_adc_n) begin
      dump_valid <= 1'b0;
      dump_last  <= 1'b0;
    end else begin
      dump_valid <= rd.rd_en;
      dump_last  <= rd.rd_en && rd_final;
    end
  end

  a_rd_in_dump: assert property (
    @(posedge clk_adc) disable iff (!rst_adc_n)
    rd.rd_en |-> rd.dump_active
  ) else $error("rd_en outside of a dump");

  // no capture may complete while the record is being read out
  a_no_capture_in_dump: assert property (
    @(posedge clk_adc) disable iff (!rst_adc_n)
    rd.dump_active |-> !rd.capture_done
  ) else $error("capture finished during a dump");

  c_full_dump: cover property (
    @(posedge clk_adc) disable iff (!rst_adc_n)
    dump_valid && dump_last ##1 !rd.dump_active
  );

endmodule

/* logic/adc_capture_top.sv */
/*
  ADC receiver with channel stream and debug capture, all on clk_adc.
  No back-pressure: the stream and the dump are never held.
*/
`timescale 1ns/10ps

module adc_capture_top import adc_pkg::*, capture_pkg::*; (
  input  logic                            clk_adc,
  input  logic                            rst_adc_n,
  // from the deserializer
  input  logic [LANE_COUNT*LANE_BITS-1:0] data_in,
  input  logic                            sampling,
  input  logic                            last,
  // capture control
  input  logic                            capture_go,
  input  logic [SEL_BITS-1:0]             capture_sel,
  // channel stream
  output logic [CHANNELS*SAMPLE_BITS-1:0] m_tdata,
  output logic                            m_tvalid,
  output logic                            m_tlast,
  // capture status and dump
  output logic                            capture_busy,
  output logic                            dump_valid,
  output lane_t                           dump_data,
  output logic                            dump_last
);

  lane_t capture_sample; // selected channel into the capture memory

  capture_rd_if rd_bus ();

  adc_lane_unpack i_adc_lane_unpack (
    .clk_adc        (clk_adc),
    .rst_adc_n      (rst_adc_n),
    .data_in        (data_in),
    .sampling       (sampling),
    .last           (last),
    .capture_sel    (capture_sel),
    .m_tdata        (m_tdata),
    .m_tvalid       (m_tvalid),
    .m_tlast        (m_tlast),
    .capture_sample (capture_sample)
  );

  capture_ram i_capture_ram (
    .clk_adc        (clk_adc),
    .rst_adc_n      (rst_adc_n),
    .capture_go     (capture_go),
    .capture_sample (capture_sample),
    .capture_busy   (capture_busy),
    .rd             (rd_bus.ram)
  );

  capture_dump i_capture_dump (
    .clk_adc    (clk_adc),
    .rst_adc_n  (rst_adc_n),
    .rd         (rd_bus.dump),
    .dump_valid (dump_valid),
    .dump_last  (dump_last),
    .dump_data  (dump_data)
  );

endmodule

/* verification/tb_adc_capture.sv */
/*
  Testbench for adc_capture_top: random interleaved words, stream and capture dump checks.
  Expected values come from the lane reorder rule applied to a history of driven words.
*/
`timescale 1ns/10ps

module tb_adc_capture import adc_pkg::*, capture_pkg::*; ();

  localparam int WORD_BITS      = LANE_COUNT * LANE_BITS;
  localparam int RESET_CYCLES   = 10;
  localparam int STREAM_CYCLES  = 300;
  localparam int SEL_SETTLE     = 10;                       // select held before each go
  localparam int CAPTURE_CYCLES = 2 * CAPTURE_DEPTH + 100;  // record, dump and gaps
  localparam int LIMIT_CYCLES   = RESET_CYCLES + STREAM_CYCLES + 3 * CAPTURE_CYCLES + 1000;
  localparam int HIST_DEPTH     = 16384;                    // above LIMIT_CYCLES, no wrap
  localparam int NUM_TESTS      = 5;
  localparam logic [31:0] SEED  = 32'h0339a61a;

  logic                            clk_adc;
  logic                            rst_adc_n;
  logic [WORD_BITS-1:0]            data_in;
  logic                            sampling;
  logic                            last;
  logic                            capture_go;
  logic [SEL_BITS-1:0]             capture_sel;
  logic [CHANNELS*SAMPLE_BITS-1:0] m_tdata;
  logic                            m_tvalid;
  logic                            m_tlast;
  logic                            capture_busy;
  logic                            dump_valid;
  lane_t                           dump_data;
  logic                            dump_last;

  logic [WORD_BITS-1:0] hist [HIST_DEPTH]; // word sampled at each edge
  logic [WORD_BITS-1:0] prev_word;         // word sampled at the latest edge
  logic                 prev_sampling;
  logic                 prev_last;
  logic                 prev_rst_n;
  int                   cycle = 0;         // index of the latest rising edge
  bit                   stim_on = 0;
  bit                   frame_mode = 0;    // distinct frame lane, ch0 kept apart from it
  int                   cur_test = 0;
  int                   exp_go_edge = -1;  // edge G of the capture being tracked
  int                   exp_sel = 0;
  int                   fall_edge = -1;    // edge where capture_busy last dropped
  bit                   busy_q = 0;
  int                   dump_idx = 0;
  int                   dumps_started = 0;
  int                   dumps_done = 0;
  int                   test_err [NUM_TESTS];
  int                   test_checks [NUM_TESTS];
  int                   dump_cycles [NUM_TESTS];

  adc_capture_top i_adc_capture_top (
    .clk_adc      (clk_adc),
    .rst_adc_n    (rst_adc_n),
    .data_in      (data_in),
    .sampling     (sampling),
    .last         (last),
    .capture_go   (capture_go),
    .capture_sel  (capture_sel),
    .m_tdata      (m_tdata),
    .m_tvalid     (m_tvalid),
    .m_tlast      (m_tlast),
    .capture_busy (capture_busy),
    .dump_valid   (dump_valid),
    .dump_data    (dump_data),
    .dump_last    (dump_last)
  );

  // lane k bit j sits at word bit j*9+k
  function automatic lane_t ref_lane(input logic [WORD_BITS-1:0] word, input int k);
    lane_t lane;
    for (int j = 0; j < LANE_BITS; j++) begin
      lane[j] = word[j*LANE_COUNT + k];
    end
    return lane;
  endfunction

  function automatic logic [WORD_BITS-1:0] put_lane(input logic [WORD_BITS-1:0] word,
                                                    input int k, input lane_t lane);
    logic [WORD_BITS-1:0] w;
    w = word;
    for (int j = 0; j < LANE_BITS; j++) begin
      w[j*LANE_COUNT + k] = lane[j];
    end
    return w;
  endfunction

  task automatic check_eq(input string sig, input logic [15:0] got, input logic [15:0] exp,
                          input int test_id);
    test_checks[test_id]++;
    assert (got === exp) else begin
      $display("mismatch at %0t ns: %s expected %h got %h", $time, sig, exp, got);
      test_err[test_id]++;
    end
  endtask

  task automatic check_true(input bit cond, input string what, input int test_id);
    test_checks[test_id]++;
    assert (cond) else begin
      $display("error at %0t ns: %s", $time, what);
      test_err[test_id]++;
    end
  endtask

  initial begin : clock_gen
    clk_adc = 1'b0;
    forever #5 clk_adc = ~clk_adc; // 10 ns period
  end

  // history of what the DUT sampled, inputs are stable at the edge
  always @(posedge clk_adc) begin
    cycle                           <= cycle + 1;
    hist[(cycle + 1) % HIST_DEPTH] <= data_in;
    prev_word                       <= data_in;
    prev_sampling                   <= sampling;
    prev_last                       <= last;
    prev_rst_n                      <= rst_adc_n;
  end

  task automatic drive_word();
    logic [95:0]          r;
    logic [WORD_BITS-1:0] w;
    lane_t                frame_pat;
    r = {$urandom, $urandom, $urandom};
    w = r[WORD_BITS-1:0];
    if (frame_mode) begin
      case (cycle % 3)
        0:       frame_pat = 10'h2aa;
        1:       frame_pat = 10'h355;
        default: frame_pat = 10'h3c3;
      endcase
      w = put_lane(w, FRAME_LANE, frame_pat);      // bit 9 always set
      w = put_lane(w, 0, ref_lane(w, 0) & 10'h1ff); // bit 9 always clear
    end
    data_in  = w;
    sampling = ($urandom % 4) != 0;
    last     = sampling && (($urandom % 8) == 0); // last only on sampled words
  endtask

  initial begin : stimulus
    forever begin
      @(posedge clk_adc);
      #1;
      if (stim_on) begin
        drive_word();
      end
    end
  end

  always @(negedge clk_adc) begin : compare
    lane_t exp_lane;
    logic  exp_valid;
    logic  exp_last;
    if (cycle > 0) begin
      for (int n = 0; n < CHANNELS; n++) begin
        check_eq($sformatf("m_tdata ch%0d", n), m_tdata[n*SAMPLE_BITS +: SAMPLE_BITS],
                 16'(ref_lane(prev_word, n)), 0);
      end
      exp_valid = prev_rst_n && rst_adc_n && prev_sampling; // flags cleared by reset
      exp_last  = prev_rst_n && rst_adc_n && prev_last;
      check_eq("m_tvalid", 16'(m_tvalid), 16'(exp_valid), 1);
      check_eq("m_tlast", 16'(m_tlast), 16'(exp_last), 1);
      if (capture_busy && !busy_q) begin
        check_true(cycle == exp_go_edge + 1, "capture_busy rose without a go one cycle before",
                   cur_test);
      end
      if (!capture_busy && busy_q) begin
        fall_edge = cycle;
      end
      busy_q = capture_busy;
      check_true(!(dump_last && !dump_valid), "dump_last high without dump_valid", cur_test);
      if (dump_valid) begin
        if (dump_idx == 0) begin
          check_true(cycle == fall_edge + 2, "dump did not start 2 cycles after capture end",
                     cur_test);
          dumps_started++;
        end
        exp_lane = ref_lane(hist[(exp_go_edge + 1 + dump_idx) % HIST_DEPTH], exp_sel);
        check_eq($sformatf("dump_data[%0d]", dump_idx), 16'(dump_data), 16'(exp_lane),
                 cur_test);
        check_eq("dump_last", 16'(dump_last), 16'(dump_idx == CAPTURE_DEPTH - 1), cur_test);
        check_true(!capture_busy, "capture_busy high during a dump", cur_test);
        if (frame_mode) begin
          check_true(dump_data !== ref_lane(hist[(exp_go_edge + 1 + dump_idx) % HIST_DEPTH],
                     FRAME_LANE), "capture returned frame lane data", cur_test);
        end
        dump_cycles[cur_test]++;
        dump_idx++;
        if (dump_idx == CAPTURE_DEPTH) begin
          dump_idx = 0;
          dumps_done++;
        end
      end else if (dump_idx != 0) begin
        check_true(1'b0, $sformatf("dump_valid dropped after %0d entries", dump_idx), cur_test);
        dump_idx = 0;
      end
    end
  end

  initial begin : watchdog
    while (cycle < LIMIT_CYCLES) begin
      @(posedge clk_adc);
    end
    $display("timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

  task automatic set_select(input int sel);
    @(posedge clk_adc);
    #1;
    capture_sel = SEL_BITS'(sel);
    repeat (SEL_SETTLE) @(posedge clk_adc); // past the synchronizer
  endtask

  // one-cycle go; tracked only when the capture is expected to (re)start
  task automatic pulse_go(input bit tracked);
    @(posedge clk_adc);
    #1;
    capture_go = 1'b1;
    @(posedge clk_adc);
    #1;
    capture_go = 1'b0;
    if (tracked) begin
      exp_go_edge = cycle; // this edge sampled the go
      exp_sel     = capture_sel;
    end
  endtask

  task automatic wait_dumps(input int n);
    while (dumps_done < n) begin
      @(negedge clk_adc);
    end
    repeat (5) @(posedge clk_adc); // let dump_active fall
  endtask

  task automatic report_test(input int t, input string name);
    $display("test %0d %s: %0d checks, %0d errors", t + 1, name, test_checks[t], test_err[t]);
  endtask

  initial begin : main
    int total_err;
    int total_checks;
    void'($urandom(SEED));
    for (int t = 0; t < NUM_TESTS; t++) begin
      test_err[t]    = 0;
      test_checks[t] = 0;
      dump_cycles[t] = 0;
    end
    rst_adc_n   = 1'b0;
    data_in     = '0;
    sampling    = 1'b1; // flags must stay low regardless
    last        = 1'b1;
    capture_go  = 1'b0;
    capture_sel = '0;
    repeat (RESET_CYCLES) @(posedge clk_adc);
    #1;
    rst_adc_n = 1'b1;
    sampling  = 1'b0;
    last      = 1'b0;
    check_true(!m_tvalid && !m_tlast, "stream flags not low right after reset", 1);
    @(negedge clk_adc);
    stim_on = 1;

    repeat (STREAM_CYCLES) @(posedge clk_adc);
    report_test(0, "stream data");
    report_test(1, "stream flags");

    cur_test = 2;
    set_select(5);
    pulse_go(1'b1);
    wait_dumps(1);
    check_true(dump_cycles[2] == CAPTURE_DEPTH, "dump length is not one full record", 2);
    report_test(2, "capture contents, select 5");

    cur_test   = 3;
    frame_mode = 1;
    set_select(0);
    pulse_go(1'b1);
    wait_dumps(2);
    frame_mode = 0;
    check_true(dump_cycles[3] == CAPTURE_DEPTH, "dump length is not one full record", 3);
    report_test(3, "select 0 and frame lane");

    cur_test = 4;
    pulse_go(1'b1);
    repeat (500) @(posedge clk_adc);
    pulse_go(1'b1); // restart mid capture
    while (dumps_started < 3) begin
      @(negedge clk_adc);
    end
    repeat (100) @(posedge clk_adc);
    pulse_go(1'b0); // lands during the dump
    wait_dumps(3);
    repeat (30) @(posedge clk_adc);
    check_true(dumps_started == 3 && !capture_busy, "go during a dump started a capture", 4);
    check_true(dump_cycles[4] == CAPTURE_DEPTH, "dump length is not one full record", 4);
    report_test(4, "restart and ignore");

    total_err    = 0;
    total_checks = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      total_err    += test_err[t];
      total_checks += test_checks[t];
    end
    $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, total_checks, total_err);
    if (total_err == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* verilog.f */
logic/adc_pkg.sv
logic/capture_pkg.sv
logic/capture_rd_if.sv
logic/adc_lane_unpack.sv
logic/capture_ram.sv
logic/capture_dump.sv
logic/adc_capture_top.sv
verification/tb_adc_capture.sv

/* Makefile */
# Verilator build and run of the ADC capture testbench
# usage: make sim, make clean; any variable can be overridden, e.g. make sim MDIR=build

VERILATOR ?= verilator
TOP       ?= tb_adc_capture
FILELIST  ?= verilog.f
MDIR      ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(MDIR) -o $(TOP)
	@out="$$(./$(MDIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(MDIR)
